/* common/puc_bus_pkg.sv */
// Register bus types
`include "puc_consts.svh"

package puc_bus_pkg;

  // --------------------------------------
  // Register map
  typedef enum logic [`PUC_ADDR_W-1:0] {
    ADDR_VERSION    = 8'h00,  // Read only
    ADDR_SCRATCH    = 8'h01,
    ADDR_COM_CNTRL  = 8'h02,  // Drives the discretes
    ADDR_LED        = 8'h03,  // LED mask, bits 6 to 0
    ADDR_SYS_PERIOD = 8'h04,  // Frame period in ms
    ADDR_SYNC       = 8'h05,  // Write restarts the system timer
    ADDR_COMM_ERR   = 8'h06,  // Sticky, write clears
    ADDR_UPTIME     = 8'h07   // Read only, ms since reset
  } reg_addr_e;

  // --------------------------------------
  // Request from a port or from the arbiter

  // Strobes are one cycle wide with addr and data valid alongside
  typedef struct packed {
    logic                   rd_strb;  // Read request
    logic                   wr_strb;  // Write request
    logic [`PUC_ADDR_W-1:0] addr;     // Register address
    logic [`PUC_DATA_W-1:0] wr_data;  // Write payload
  } reg_req_t;

  // Response back to a port
  typedef struct packed {
    logic                   rdy_strb; // Access done, one cycle
    logic [`PUC_DATA_W-1:0] rd_data;  // Valid with rdy_strb on a read
  } reg_rsp_t;

endpackage : puc_bus_pkg

/* common/puc_consts.svh */
// Housekeeping core constants
`ifndef PUC_CONSTS_SVH
`define PUC_CONSTS_SVH

// --------------------------------------
// Timebase
`define PUC_CLK_PER_US       50               // 50 MHz system clock
`define PUC_US_PER_MS        1000
`define PUC_US_CNT_W         6                // Holds 0 to 49
`define PUC_MS_CNT_W         10               // Holds 0 to 999

// --------------------------------------
// Register bus and register widths
`define PUC_ADDR_W           8
`define PUC_DATA_W           36
`define PUC_PERIOD_W         16               // System timer period in ms
`define PUC_UPTIME_W         32               // Uptime in ms
`define PUC_ERR_W            6                // Two error bits per port
`define PUC_LED_W            8                // Status LEDs, active low
`define PUC_COM_W            2                // COM control bits

// --------------------------------------
// Fixed and reset values
`define PUC_FPGA_VERSION     16'h0177
`define PUC_SYS_PERIOD_RST   16'd1000         // One frame per second
`define PUC_BAD_ADDR_DATA    36'hE_0BAD_ADD0  // Unmapped read pattern

`endif

/* common/puc_ctrl_pkg.sv */
// Arbiter control types
package puc_ctrl_pkg;

  // --------------------------------------
  // Arbiter FSM
  typedef enum logic [1:0] {
    ARB_IDLE    = 2'd0,  // Waiting for a pending port
    ARB_ACCESS  = 2'd1,  // Strobe on the register bus
    ARB_RESPOND = 2'd2   // Read data back with ready strobe
  } arb_state_e;

  // Port index, lowest value wins
  typedef enum logic [1:0] {
    PORT_TST = 2'd0,  // Test port
    PORT_DNL = 2'd1,  // Downlink
    PORT_SUB = 2'd2   // Sublink
  } port_sel_e;

endpackage : puc_ctrl_pkg

/* flist.f */
+incdir+common
common/puc_bus_pkg.sv
common/puc_ctrl_pkg.sv
logic/bus_arbiter.sv
logic/timing_strobes.sv
regs/reg_bank.sv
logic/puc_control_top.sv
sim/puc_control_assertions.sv
sim/puc_control_tb.sv

/* logic/bus_arbiter.sv */
// Fixed-priority register bus arbiter
`timescale 1ns/1ps
`include "puc_consts.svh"

module bus_arbiter
(
  input  logic                    clk,            // System clock
  input  logic                    reset,          // Sync reset, active high
  input  puc_bus_pkg::reg_req_t   tst_req_i,      // Highest priority
  input  puc_bus_pkg::reg_req_t   dnl_req_i,
  input  puc_bus_pkg::reg_req_t   sub_req_i,      // Lowest priority
  output puc_bus_pkg::reg_rsp_t   tst_rsp_o,
  output puc_bus_pkg::reg_rsp_t   dnl_rsp_o,
  output puc_bus_pkg::reg_rsp_t   sub_rsp_o,
  output puc_bus_pkg::reg_req_t   bus_req_o,      // To register bank
  input  logic [`PUC_DATA_W-1:0]  bus_rd_data_i   // One cycle after strobe
);

  localparam int N_PORTS = 3;

  puc_bus_pkg::reg_req_t    port_req   [N_PORTS]; // Indexed by port_sel_e
  puc_bus_pkg::reg_rsp_t    port_rsp   [N_PORTS];
  puc_bus_pkg::reg_req_t    pend_req_q [N_PORTS]; // Latched addr and data
  logic [N_PORTS-1:0]       pend_vld_q;           // One slot per port
  logic [N_PORTS-1:0]       port_strb;            // New request this cycle
  logic [N_PORTS-1:0]       rdy_strb;
  puc_ctrl_pkg::arb_state_e state_q;
  puc_ctrl_pkg::port_sel_e  sel_q;                // Port being served
  puc_ctrl_pkg::port_sel_e  sel_next;             // Winner of pending set
  puc_bus_pkg::reg_req_t    sel_req;

  assign port_req[puc_ctrl_pkg::PORT_TST] = tst_req_i;
  assign port_req[puc_ctrl_pkg::PORT_DNL] = dnl_req_i;
  assign port_req[puc_ctrl_pkg::PORT_SUB] = sub_req_i;

  // --------------------------------------
  // Pending slots
  always_comb
  begin
    for (int i = 0; i < N_PORTS; i++)
      port_strb[i] = port_req[i].rd_strb | port_req[i].wr_strb;
  end

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < N_PORTS; i++)
    begin
      if (reset)
        pend_vld_q[i] <= 1'b0;
      else if (port_strb[i])
        pend_vld_q[i] <= 1'b1;                    // New strobe wins over clear
      else if (rdy_strb[i])
        pend_vld_q[i] <= 1'b0;                    // Served
    end
  end

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < N_PORTS; i++)
      if (port_strb[i])
        pend_req_q[i] <= port_req[i];
  end

  // --------------------------------------
  // Priority select and FSM
  always_comb
  begin
    if (pend_vld_q[puc_ctrl_pkg::PORT_TST])
      sel_next = puc_ctrl_pkg::PORT_TST;
    else if (pend_vld_q[puc_ctrl_pkg::PORT_DNL])
      sel_next = puc_ctrl_pkg::PORT_DNL;
    else
      sel_next = puc_ctrl_pkg::PORT_SUB;          // Only used when it is pending
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state_q <= puc_ctrl_pkg::ARB_IDLE;
      sel_q   <= puc_ctrl_pkg::PORT_TST;
    end
    else
    begin
      case (state_q)
        puc_ctrl_pkg::ARB_IDLE:
          if (|pend_vld_q)
          begin
            state_q <= puc_ctrl_pkg::ARB_ACCESS;
            sel_q   <= sel_next;                  // Grant held for the access
          end
        puc_ctrl_pkg::ARB_ACCESS:
          state_q <= puc_ctrl_pkg::ARB_RESPOND;   // Bank registers read data
        default:
          state_q <= puc_ctrl_pkg::ARB_IDLE;      // Respond lasts one cycle
      endcase
    end
  end

  // --------------------------------------
  // Bus drive and response routing
  assign sel_req = pend_req_q[sel_q];

  always_comb
  begin
    bus_req_o         = sel_req;
    bus_req_o.rd_strb = (state_q == puc_ctrl_pkg::ARB_ACCESS) && sel_req.rd_strb;
    bus_req_o.wr_strb = (state_q == puc_ctrl_pkg::ARB_ACCESS) && sel_req.wr_strb;
  end

  always_comb
  begin
    for (int i = 0; i < N_PORTS; i++)
    begin
      rdy_strb[i]          = (state_q == puc_ctrl_pkg::ARB_RESPOND) && (sel_q == i);
      port_rsp[i].rdy_strb = rdy_strb[i];
      port_rsp[i].rd_data  = rdy_strb[i] ? bus_rd_data_i : '0;  // Quiet when idle
    end
  end

  assign tst_rsp_o = port_rsp[puc_ctrl_pkg::PORT_TST];
  assign dnl_rsp_o = port_rsp[puc_ctrl_pkg::PORT_DNL];
  assign sub_rsp_o = port_rsp[puc_ctrl_pkg::PORT_SUB];

endmodule : bus_arbiter

/* logic/puc_control_top.sv */
// Pumping-unit controller housekeeping top
`timescale 1ns/1ps
`include "puc_consts.svh"

module puc_control_top
(
  input  logic                    clk,           // 50 MHz system clock
  input  logic                    reset,         // Sync reset, active high
  input  puc_bus_pkg::reg_req_t   tst_req_i,     // Test port request
  input  puc_bus_pkg::reg_req_t   dnl_req_i,     // Downlink request
  input  puc_bus_pkg::reg_req_t   sub_req_i,     // Sublink request
  output puc_bus_pkg::reg_rsp_t   tst_rsp_o,     // Test port response
  output puc_bus_pkg::reg_rsp_t   dnl_rsp_o,     // Downlink response
  output puc_bus_pkg::reg_rsp_t   sub_rsp_o,     // Sublink response
  input  logic [`PUC_ERR_W-1:0]   comm_err_i,    // Port errors, tst dnl sub
  output logic [`PUC_LED_W-1:0]   status_led_o,  // Active low
  output logic                    discrete1_o,   // Normally high to COM
  output logic                    discrete2_o,   // Normally low to COM
  output logic                    ready_o        // Logic is running
);

  puc_bus_pkg::reg_req_t          bus_req;       // Arbitrated access
  logic [`PUC_DATA_W-1:0]         bus_rd_data;   // Registered read data
  logic [`PUC_PERIOD_W-1:0]       sys_period;    // Frame period in ms
  logic                           sync_strb;     // Timer restart
  logic                           strb_1ms;      // Millisecond tick
  logic                           frame_led;     // Toggles every frame

  // --------------------------------------
  // Port arbitration
  bus_arbiter bus_arbiter_i
  (
    .clk           (clk),
    .reset         (reset),
    .tst_req_i     (tst_req_i),
    .dnl_req_i     (dnl_req_i),
    .sub_req_i     (sub_req_i),
    .tst_rsp_o     (tst_rsp_o),
    .dnl_rsp_o     (dnl_rsp_o),
    .sub_rsp_o     (sub_rsp_o),
    .bus_req_o     (bus_req),
    .bus_rd_data_i (bus_rd_data)
  );

  // --------------------------------------
  // Timebase and system timer
  timing_strobes timing_strobes_i
  (
    .clk           (clk),
    .reset         (reset),
    .sys_period_i  (sys_period),
    .sync_strb_i   (sync_strb),
    .strb_1ms_o    (strb_1ms),
    .frame_led_o   (frame_led)
  );

  // --------------------------------------
  // Register bank and discretes
  reg_bank reg_bank_i
  (
    .clk           (clk),
    .reset         (reset),
    .bus_req_i     (bus_req),
    .bus_rd_data_o (bus_rd_data),
    .comm_err_i    (comm_err_i),
    .strb_1ms_i    (strb_1ms),
    .frame_led_i   (frame_led),
    .sys_period_o  (sys_period),
    .sync_strb_o   (sync_strb),
    .status_led_o  (status_led_o),
    .discrete1_o   (discrete1_o),
    .discrete2_o   (discrete2_o),
    .ready_o       (ready_o)
  );

endmodule : puc_control_top

/* logic/timing_strobes.sv */
// Timebase and system frame timer
`timescale 1ns/1ps
`include "puc_consts.svh"

module timing_strobes
(
  input  logic                     clk,           // 50 MHz system clock
  input  logic                     reset,         // Sync reset, active high
  input  logic [`PUC_PERIOD_W-1:0] sys_period_i,  // Frame period in ms
  input  logic                     sync_strb_i,   // Restart ms and frame count
  output logic                     strb_1ms_o,    // One cycle every ms
  output logic                     frame_led_o    // Toggles each frame
);

  logic [`PUC_US_CNT_W-1:0]  us_cnt_q;            // Clock prescaler
  logic [`PUC_MS_CNT_W-1:0]  ms_cnt_q;            // Counts us ticks
  logic [`PUC_PERIOD_W-1:0]  sys_cnt_q;           // Counts ms ticks
  logic                      strb_1us;
  logic                      sys_tmr_strb;        // Frame expiry

  // --------------------------------------
  // Microsecond and millisecond strobes
  assign strb_1us   = (us_cnt_q == (`PUC_CLK_PER_US - 1));
  assign strb_1ms_o = strb_1us && (ms_cnt_q == (`PUC_US_PER_MS - 1));

  always_ff @(posedge clk)
  begin
    if (reset || strb_1us)
      us_cnt_q <= '0;                             // Free running, sync leaves it
    else
      us_cnt_q <= us_cnt_q + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (reset || sync_strb_i || strb_1ms_o)
      ms_cnt_q <= '0;
    else if (strb_1us)
      ms_cnt_q <= ms_cnt_q + 1'b1;
  end

  // --------------------------------------
  // Programmable system timer
  // A period of zero wraps the full 16-bit count
  assign sys_tmr_strb = !sync_strb_i && strb_1ms_o &&
                        (sys_cnt_q == sys_period_i - 1'b1);

  always_ff @(posedge clk)
  begin
    if (reset || sync_strb_i || sys_tmr_strb)
      sys_cnt_q <= '0;
    else if (strb_1ms_o)
      sys_cnt_q <= sys_cnt_q + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      frame_led_o <= 1'b0;                        // LED off after reset
    else if (sys_tmr_strb)
      frame_led_o <= ~frame_led_o;
  end

endmodule : timing_strobes

/* regs/reg_bank.sv */
// Housekeeping register bank
`timescale 1ns/1ps
`include "puc_consts.svh"

module reg_bank
(
  input  logic                     clk,            // System clock
  input  logic                     reset,          // Sync reset, active high
  input  puc_bus_pkg::reg_req_t    bus_req_i,      // Arbitrated access
  output logic [`PUC_DATA_W-1:0]   bus_rd_data_o,  // Valid one cycle after rd_strb
  input  logic [`PUC_ERR_W-1:0]    comm_err_i,     // Error pulses from the ports
  input  logic                     strb_1ms_i,     // Uptime tick
  input  logic                     frame_led_i,    // Frame toggle for LED 7
  output logic [`PUC_PERIOD_W-1:0] sys_period_o,   // To system timer
  output logic                     sync_strb_o,    // One cycle timer restart
  output logic [`PUC_LED_W-1:0]    status_led_o,   // Active low
  output logic                     discrete1_o,    // Inverted COM bit 0
  output logic                     discrete2_o,    // COM bit 1
  output logic                     ready_o         // High once out of reset
);

  logic [`PUC_DATA_W-1:0]   scratch_q;
  logic [`PUC_COM_W-1:0]    com_cntrl_q;
  logic [`PUC_LED_W-2:0]    led_mask_q;            // LED 7 is the frame LED
  logic [`PUC_PERIOD_W-1:0] sys_period_q;
  logic [`PUC_ERR_W-1:0]    comm_err_q;            // Sticky error bits
  logic [`PUC_UPTIME_W-1:0] uptime_q;              // ms since reset
  logic                     sync_q;
  logic                     ready_q;
  logic [`PUC_DATA_W-1:0]   rd_mux;
  logic [`PUC_DATA_W-1:0]   rd_data_q;
  logic                     err_wr;                // Write to COMM_ERR

  // --------------------------------------
  // Write decode
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      scratch_q    <= '0;
      com_cntrl_q  <= '0;                          // Discrete1 high, discrete2 low
      led_mask_q   <= '0;                          // All LEDs off
      sys_period_q <= `PUC_SYS_PERIOD_RST;
      sync_q       <= 1'b0;
      ready_q      <= 1'b0;
    end
    else
    begin
      sync_q  <= 1'b0;
      ready_q <= 1'b1;
      if (bus_req_i.wr_strb)
      begin
        case (bus_req_i.addr)
          puc_bus_pkg::ADDR_SCRATCH:    scratch_q    <= bus_req_i.wr_data;
          puc_bus_pkg::ADDR_COM_CNTRL:  com_cntrl_q  <= bus_req_i.wr_data[`PUC_COM_W-1:0];
          puc_bus_pkg::ADDR_LED:        led_mask_q   <= bus_req_i.wr_data[`PUC_LED_W-2:0];
          puc_bus_pkg::ADDR_SYS_PERIOD: sys_period_q <= bus_req_i.wr_data[`PUC_PERIOD_W-1:0];
          puc_bus_pkg::ADDR_SYNC:       sync_q       <= 1'b1;
          default: ;                               // VERSION and UPTIME ignore writes
        endcase
      end
    end
  end

  // --------------------------------------
  // Sticky errors and uptime
  assign err_wr = bus_req_i.wr_strb && (bus_req_i.addr == puc_bus_pkg::ADDR_COMM_ERR);

  always_ff @(posedge clk)
  begin
    if (reset)
      comm_err_q <= '0;
    else if (err_wr)
      comm_err_q <= comm_err_i;                    // Clear but keep new errors
    else
      comm_err_q <= comm_err_q | comm_err_i;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      uptime_q <= '0;
    else if (strb_1ms_i)
      uptime_q <= uptime_q + 1'b1;
  end

  // --------------------------------------
  // Registered read path
  always_comb
  begin
    rd_mux = '0;                                   // Narrow fields zero-extend
    case (bus_req_i.addr)
      puc_bus_pkg::ADDR_VERSION:    rd_mux[15:0]               = `PUC_FPGA_VERSION;
      puc_bus_pkg::ADDR_SCRATCH:    rd_mux                     = scratch_q;
      puc_bus_pkg::ADDR_COM_CNTRL:  rd_mux[`PUC_COM_W-1:0]     = com_cntrl_q;
      puc_bus_pkg::ADDR_LED:        rd_mux[`PUC_LED_W-2:0]     = led_mask_q;
      puc_bus_pkg::ADDR_SYS_PERIOD: rd_mux[`PUC_PERIOD_W-1:0]  = sys_period_q;
      puc_bus_pkg::ADDR_SYNC:       rd_mux                     = '0;  // Write only
      puc_bus_pkg::ADDR_COMM_ERR:   rd_mux[`PUC_ERR_W-1:0]     = comm_err_q;
      puc_bus_pkg::ADDR_UPTIME:     rd_mux[`PUC_UPTIME_W-1:0]  = uptime_q;
      default:                      rd_mux                     = `PUC_BAD_ADDR_DATA;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (bus_req_i.rd_strb)
      rd_data_q <= rd_mux;
  end

  // --------------------------------------
  // Outputs
  assign bus_rd_data_o = rd_data_q;
  assign sys_period_o  = sys_period_q;
  assign sync_strb_o   = sync_q;
  assign status_led_o  = ~{frame_led_i, led_mask_q};  // Low lights the LED
  assign discrete1_o   = ~com_cntrl_q[0];
  assign discrete2_o   = com_cntrl_q[1];
  assign ready_o       = ready_q;

endmodule : reg_bank

/* sim/puc_control_assertions.sv */
// Arbiter protocol assertions
`timescale 1ns/1ps

module puc_control_assertions
(
  input logic       clk,
  input logic       reset,
  input logic [2:0] port_strb_i,   // New request per port
  input logic [2:0] pend_vld_i,    // Pending slot per port
  input logic [2:0] rdy_strb_i,    // Ready strobe per port
  input logic       bus_strb_i     // Read or write strobe to the bank
);

  // --------------------------------------
  // Responses
  // At most one ready strobe and only to a pending port
  rdy_onehot: assert property (@(posedge clk) disable iff (reset)
    $onehot0(rdy_strb_i) && ((rdy_strb_i & ~pend_vld_i) == 3'b000))
    else $error("Ready strobe on more than one port or on a port with nothing pending");

  // --------------------------------------
  // Requests
  tst_no_restrobe: assert property (@(posedge clk) disable iff (reset)
    port_strb_i[0] |-> !pend_vld_i[0])
    else $error("Test port strobed while its request was pending");

  dnl_no_restrobe: assert property (@(posedge clk) disable iff (reset)
    port_strb_i[1] |-> !pend_vld_i[1])
    else $error("Downlink port strobed while its request was pending");

  sub_no_restrobe: assert property (@(posedge clk) disable iff (reset)
    port_strb_i[2] |-> !pend_vld_i[2])
    else $error("Sublink port strobed while its request was pending");

  // Bank access is a single-cycle strobe
  bus_one_cycle: assert property (@(posedge clk) disable iff (reset)
    bus_strb_i |=> !bus_strb_i)
    else $error("Register bus strobe lasted more than one cycle");

endmodule : puc_control_assertions

bind bus_arbiter puc_control_assertions puc_control_assertions_i
(
  .clk         (clk),
  .reset       (reset),
  .port_strb_i (port_strb),
  .pend_vld_i  (pend_vld_q),
  .rdy_strb_i  (rdy_strb),
  .bus_strb_i  (bus_req_o.rd_strb | bus_req_o.wr_strb)
);

/* sim/puc_control_tb.sv */
// Housekeeping core testbench
`timescale 1ns/1ps
`include "puc_consts.svh"

module puc_control_tb;

  localparam int CLK_PERIOD  = 20;
  localparam int RDY_TIMEOUT = 100;                   // Cycles to wait for rdy_strb
  localparam int LED_TIMEOUT = 60000;                 // Cycles to wait for a frame toggle

  logic                  clk;
  logic                  reset;
  puc_bus_pkg::reg_req_t req [3];                     // tst, dnl, sub
  puc_bus_pkg::reg_rsp_t rsp [3];
  logic [5:0]            comm_err;
  logic [7:0]            status_led;
  logic                  discrete1;
  logic                  discrete2;
  logic                  ready;

  integer      seed;
  int          err_cnt;
  int          chk_cnt;
  int          done_cnt [3];                          // Responses seen per port
  logic [35:0] last_rd  [3];
  logic [35:0] exp_data [3];
  logic        exp_chk  [3];
  logic        exp_lat  [3];
  logic        exp_busy [3];
  time         issue_t  [3];
  bit          check_latency;
  int          order_q [$];                           // Port order of rdy_strb

  // Register map model
  logic [35:0] m_scratch;
  logic [1:0]  m_com;
  logic [6:0]  m_led;
  logic [15:0] m_period;
  logic [5:0]  m_err;

  logic [7:0]  addr;
  logic [35:0] data;
  logic [6:0]  led_exp;
  logic [5:0]  err_bits;
  logic [35:0] up0;
  int          e0;
  int          s [3];
  time         t0;
  time         t1;

  always #(CLK_PERIOD / 2) clk = ~clk;

  puc_control_top puc_control_top_i
  (
    .clk          (clk),
    .reset        (reset),
    .tst_req_i    (req[0]),
    .dnl_req_i    (req[1]),
    .sub_req_i    (req[2]),
    .tst_rsp_o    (rsp[0]),
    .dnl_rsp_o    (rsp[1]),
    .sub_rsp_o    (rsp[2]),
    .comm_err_i   (comm_err),
    .status_led_o (status_led),
    .discrete1_o  (discrete1),
    .discrete2_o  (discrete2),
    .ready_o      (ready)
  );

  // --------------------------------------
  // Reference model
  function automatic logic [35:0] expected_read(input logic [7:0] a);
    logic [35:0] val;
    begin
      val = '0;                                       // Narrow registers zero-extend
      case (a)
        puc_bus_pkg::ADDR_VERSION:    val[15:0] = 16'h0177;
        puc_bus_pkg::ADDR_SCRATCH:    val       = m_scratch;
        puc_bus_pkg::ADDR_COM_CNTRL:  val[1:0]  = m_com;
        puc_bus_pkg::ADDR_LED:        val[6:0]  = m_led;
        puc_bus_pkg::ADDR_SYS_PERIOD: val[15:0] = m_period;
        puc_bus_pkg::ADDR_COMM_ERR:   val[5:0]  = m_err;
        puc_bus_pkg::ADDR_SYNC,
        puc_bus_pkg::ADDR_UPTIME:     val       = '0;  // Uptime is compared apart
        default:                      val       = `PUC_BAD_ADDR_DATA;
      endcase
      expected_read = val;
    end
  endfunction

  function automatic void model_write(input logic [7:0] a, input logic [35:0] d);
    case (a)
      puc_bus_pkg::ADDR_SCRATCH:    m_scratch = d;
      puc_bus_pkg::ADDR_COM_CNTRL:  m_com     = d[1:0];
      puc_bus_pkg::ADDR_LED:        m_led     = d[6:0];
      puc_bus_pkg::ADDR_SYS_PERIOD: m_period  = d[15:0];
      puc_bus_pkg::ADDR_COMM_ERR:   m_err     = '0;   // No error pulse during the write
      default: ;                                      // Read-only or unmapped
    endcase
  endfunction

  function automatic string port_name(input int p);
    port_name = (p == 0) ? "tst" : (p == 1) ? "dnl" : "sub";
  endfunction

  function int pick_port();
    pick_port = $unsigned($random(seed)) % 3;
  endfunction

  task check_value(input string name, input logic [35:0] exp, input logic [35:0] got);
    chk_cnt++;
    if (got !== exp)
    begin
      $display("ERROR %s: expected 0x%h, got 0x%h", name, exp, got);
      err_cnt++;
    end
  endtask

  // --------------------------------------
  // Port drivers
  task post_req(input int p, input bit is_rd, input logic [7:0] a,
                input logic [35:0] d, input bit chk);
    puc_bus_pkg::reg_req_t r;
    begin
      r.rd_strb   = is_rd;
      r.wr_strb   = !is_rd;
      r.addr      = a;
      r.wr_data   = d;
      exp_data[p] = expected_read(a);                 // Value before this access
      exp_chk[p]  = is_rd && chk;
      exp_lat[p]  = check_latency;
      exp_busy[p] = 1'b1;
      issue_t[p]  = $time;
      if (!is_rd)
        model_write(a, d);
      req[p] <= r;
    end
  endtask

  task clear_reqs();
    req[0] <= '0;
    req[1] <= '0;
    req[2] <= '0;
  endtask

  task wait_rdy(input int p, input int start);
    int t;
    begin
      t = 0;
      while (done_cnt[p] == start && t < RDY_TIMEOUT)
      begin
        @(posedge clk);
        t++;
      end
      if (done_cnt[p] == start)
      begin
        $display("Timeout waiting for the ready strobe on the %s port", port_name(p));
        err_cnt++;
      end
    end
  endtask

  task send_one(input int p, input bit is_rd, input logic [7:0] a,
                input logic [35:0] d, input bit chk);
    int start;
    begin
      start = done_cnt[p];
      @(posedge clk);
      post_req(p, is_rd, a, d, chk);
      @(posedge clk);
      clear_reqs();                                   // One-cycle strobe
      wait_rdy(p, start);
    end
  endtask

  task wait_led_toggle(output time t_edge);
    logic prev;
    int   t;
    begin
      prev = status_led[7];
      t    = 0;
      while (status_led[7] === prev && t < LED_TIMEOUT)
      begin
        @(posedge clk);
        t++;
      end
      if (status_led[7] === prev)
      begin
        $display("Timeout waiting for the frame LED to toggle");
        err_cnt++;
      end
      t_edge = $time;
    end
  endtask

  task report_test(input int num, input string name, input int err_start);
    $display("Test %0d %s done with %0d errors", num, name, err_cnt - err_start);
  endtask

  // --------------------------------------
  // Response checker
  always @(posedge clk)
  begin
    for (int p = 0; p < 3; p++)
    begin
      if (rsp[p].rdy_strb)
      begin
        if (!exp_busy[p])
        begin
          $display("Ready strobe on the %s port without a request", port_name(p));
          err_cnt++;
        end
        if (exp_chk[p])
          check_value($sformatf("%s_rsp_o.rd_data", port_name(p)), exp_data[p],
                      rsp[p].rd_data);
        // Strobe is sampled one edge after it is driven
        if (exp_lat[p] && (($time - issue_t[p]) / CLK_PERIOD - 1) != 3)
        begin
          $display("Ready strobe on the %s port came %0d cycles after the request, not 3",
                   port_name(p), ($time - issue_t[p]) / CLK_PERIOD - 1);
          err_cnt++;
        end
        last_rd[p]  = rsp[p].rd_data;
        exp_busy[p] = 1'b0;
        order_q.push_back(p);
        done_cnt[p]++;
      end
    end
  end

  // --------------------------------------
  // Stimulus
  initial
  begin
    seed     = 32'h80caa2e5;
    clk      = 1'b0;
    reset    = 1'b1;
    req[0]   = '0;
    req[1]   = '0;
    req[2]   = '0;
    comm_err = '0;
    err_cnt  = 0;
    chk_cnt  = 0;
    for (int p = 0; p < 3; p++)
    begin
      done_cnt[p] = 0;
      exp_busy[p] = 1'b0;
      exp_chk[p]  = 1'b0;
      exp_lat[p]  = 1'b0;
    end
    m_scratch = '0;
    m_com     = '0;
    m_led     = '0;
    m_period  = 16'd1000;
    m_err     = '0;
    check_latency = 1'b1;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    repeat (2) @(posedge clk);

    // Reset values and version
    e0 = err_cnt;
    check_value("status_led_o", 36'hFF, status_led);
    check_value("discrete1_o", 36'h1, discrete1);
    check_value("discrete2_o", 36'h0, discrete2);
    check_value("ready_o", 36'h1, ready);
    send_one(0, 1'b1, puc_bus_pkg::ADDR_VERSION, '0, 1'b1);
    report_test(1, "reset state", e0);

    // Writes then reads of the writable registers
    e0 = err_cnt;
    for (int i = 0; i < 40; i++)
    begin
      addr = ($unsigned($random(seed)) % 4) + 1;      // SCRATCH to SYS_PERIOD
      data = {$random(seed), $random(seed)};
      send_one(pick_port(), 1'b0, addr, data, 1'b0);
      send_one(pick_port(), 1'b1, addr, '0, 1'b1);
      led_exp = ~m_led;
      check_value("status_led_o[6:0]", led_exp, status_led[6:0]);
      check_value("discrete1_o", !m_com[0], discrete1);
      check_value("discrete2_o", m_com[1], discrete2);
    end
    data = {$random(seed), $random(seed)};
    send_one(pick_port(), 1'b0, puc_bus_pkg::ADDR_VERSION, data, 1'b0);
    send_one(pick_port(), 1'b1, puc_bus_pkg::ADDR_VERSION, '0, 1'b1);
    addr = 8 + ($unsigned($random(seed)) % 248);      // Unmapped range
    send_one(pick_port(), 1'b0, addr, data, 1'b0);
    send_one(pick_port(), 1'b1, addr, '0, 1'b1);
    send_one(pick_port(), 1'b1, puc_bus_pkg::ADDR_SCRATCH, '0, 1'b1);
    report_test(2, "random accesses", e0);

    // All three ports in one cycle
    e0 = err_cnt;
    check_latency = 1'b0;
    order_q.delete();
    data = {$random(seed), $random(seed)};
    for (int p = 0; p < 3; p++)
      s[p] = done_cnt[p];
    @(posedge clk);
    post_req(0, 1'b0, puc_bus_pkg::ADDR_SCRATCH, data, 1'b0);
    post_req(1, 1'b1, puc_bus_pkg::ADDR_SCRATCH, '0, 1'b1);  // Sees the test port write
    post_req(2, 1'b1, puc_bus_pkg::ADDR_COM_CNTRL, '0, 1'b1);
    @(posedge clk);
    clear_reqs();
    wait_rdy(0, s[0]);
    wait_rdy(1, s[1]);
    wait_rdy(2, s[2]);
    chk_cnt++;
    if (order_q.size() != 3 || order_q[0] != 0 || order_q[1] != 1 || order_q[2] != 2)
    begin
      $display("Ready strobes did not arrive in the order test, downlink, sublink");
      err_cnt++;
    end
    report_test(3, "simultaneous requests", e0);

    // Sticky communication errors
    e0 = err_cnt;
    for (int i = 0; i < 4; i++)
    begin
      @(posedge clk);
      err_bits = $random(seed);
      comm_err <= err_bits;
      m_err     = m_err | err_bits;
      @(posedge clk);
      comm_err <= '0;
    end
    send_one(pick_port(), 1'b1, puc_bus_pkg::ADDR_COMM_ERR, '0, 1'b1);
    send_one(pick_port(), 1'b0, puc_bus_pkg::ADDR_COMM_ERR, '0, 1'b0);
    send_one(pick_port(), 1'b1, puc_bus_pkg::ADDR_COMM_ERR, '0, 1'b1);
    report_test(4, "sticky errors", e0);

    // Frame timer and uptime
    e0 = err_cnt;
    send_one(0, 1'b1, puc_bus_pkg::ADDR_UPTIME, '0, 1'b0);
    up0 = last_rd[0];
    send_one(0, 1'b0, puc_bus_pkg::ADDR_SYS_PERIOD, 36'd1, 1'b0);
    send_one(0, 1'b0, puc_bus_pkg::ADDR_SYNC, '0, 1'b0);
    wait_led_toggle(t0);
    wait_led_toggle(t1);
    chk_cnt++;
    if ((t1 - t0) / CLK_PERIOD != 50000)
    begin
      $display("Frame LED toggled %0d cycles apart instead of 50000", (t1 - t0) / CLK_PERIOD);
      err_cnt++;
    end
    send_one(1, 1'b1, puc_bus_pkg::ADDR_UPTIME, '0, 1'b0);
    chk_cnt++;
    if (last_rd[1] <= up0)
    begin
      $display("Uptime did not advance, first read 0x%h, later read 0x%h", up0, last_rd[1]);
      err_cnt++;
    end
    report_test(5, "timer and uptime", e0);

    $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule : puc_control_tb
